//--- Makefile
# Verilator simulation of the instruction cache

.PHONY: sim clean

sim:
	verilator --binary --assert -f all.f --top-module icache_tb -Mdir obj_dir -o icache_sim
	./obj_dir/icache_sim > sim.log 2>&1 || true
	cat sim.log
	! grep -qF '*** TEST FAILED ***' sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
hdl/icache_geom_pkg.sv
hdl/icache_addr_pkg.sv
hdl/icache_ctrl.sv
hdl/icache_arrays.sv
hdl/icache_hit_select.sv
hdl/icache_replace.sv
hdl/icache_top.sv
test/icache_assertions.sv
test/icache_tb.sv

//--- hdl/icache_addr_pkg.sv
// fetch address views
package icache_addr_pkg;

  // one fetch address, seen as a raw word or split into cache fields
  typedef union packed {
    logic [icache_geom_pkg::addr_w-1:0] raw;
    struct packed {
      logic [icache_geom_pkg::tag_w-1:0]      tag;
      logic [icache_geom_pkg::set_w-1:0]      set_idx;
      // word inside the line
      logic [icache_geom_pkg::offset_w-3:0]   word;
      // byte inside the word, ignored by the cache
      logic [1:0]                             byte_off;
    } f;
  } fetch_addr_u;

  function automatic logic [icache_geom_pkg::tag_w-1:0] get_tag(fetch_addr_u a);
    return a.f.tag;
  endfunction

  function automatic logic [icache_geom_pkg::set_w-1:0] get_set(fetch_addr_u a);
    return a.f.set_idx;
  endfunction

  function automatic logic [icache_geom_pkg::offset_w-3:0] get_word(fetch_addr_u a);
    return a.f.word;
  endfunction

  // line aligned address for the memory side
  function automatic logic [icache_geom_pkg::addr_w-1:0] line_base(fetch_addr_u a);
    return {a.raw[icache_geom_pkg::addr_w-1:icache_geom_pkg::offset_w],
            {icache_geom_pkg::offset_w{1'b0}}};
  endfunction

endpackage

//--- hdl/icache_arrays.sv
// tag and data arrays
module icache_arrays (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    rd_en_i,
  input  logic                                                    fill_we_i,
  input  logic                                                    clear_we_i,
  input  logic [icache_geom_pkg::set_w-1:0]                       set_i,
  input  logic [icache_geom_pkg::tag_w-1:0]                       tag_i,
  input  logic [icache_geom_pkg::way_w-1:0]                       way_i,
  input  logic [icache_geom_pkg::line_w-1:0]                      line_i,
  output logic [icache_geom_pkg::num_ways-1:0][icache_geom_pkg::tag_w-1:0]  tag_o,
  output logic [icache_geom_pkg::num_ways-1:0]                    valid_o,
  output logic [icache_geom_pkg::num_ways-1:0][icache_geom_pkg::line_w-1:0] line_o
);
  import icache_geom_pkg::*;

  for (genvar w = 0; w < num_ways; w++) begin : gen_way
    // msb is the valid bit
    logic [tag_w:0]    tag_mem  [num_sets];
    logic [line_w-1:0] line_mem [num_sets];
    logic [tag_w-1:0]  tag_q;
    logic [line_w-1:0] line_q;
    logic              valid_q;
    logic              fill_sel;

    // only the chosen way takes a fill
    assign fill_sel = fill_we_i && (way_i == way_w'(w));

    // single write port, a fill wins over a clear
    always_ff @(posedge clk_i) begin
      if (fill_sel) begin
        tag_mem[set_i]  <= {1'b1, tag_i};
        line_mem[set_i] <= line_i;
      end else if (clear_we_i) begin
        // every way of the set drops its valid bit
        tag_mem[set_i]  <= {1'b0, tag_i};
      end
    end

    // read data holds while no read is enabled
    always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
        tag_q  <= tag_mem[set_i][tag_w-1:0];
        line_q <= line_mem[set_i];
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= 1'b0;
      end else if (rd_en_i) begin
        valid_q <= tag_mem[set_i][tag_w];
      end
    end

    assign tag_o[w]   = tag_q;
    assign line_o[w]  = line_q;
    assign valid_o[w] = valid_q;
  end

endmodule

//--- hdl/icache_ctrl.sv
// instruction cache controller
module icache_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // cpu side, wishbone classic slave
  input  logic                                  fetch_cyc_i,
  input  logic                                  fetch_stb_i,
  input  icache_addr_pkg::fetch_addr_u          fetch_adr_i,
  output logic                                  fetch_ack_o,
  // cache control
  input  logic                                  flush_i,
  input  logic                                  en_i,
  output logic                                  miss_o,
  output logic                                  busy_o,
  // tag compare result for the looked up set
  input  logic                                  hit_i,
  // memory side, wishbone classic master
  output logic                                  mem_cyc_o,
  output logic                                  mem_stb_o,
  output logic [icache_geom_pkg::addr_w-1:0]    mem_adr_o,
  input  logic                                  mem_ack_i,
  // array control
  output logic                                  rd_en_o,
  output logic                                  fill_we_o,
  output logic                                  clear_we_o,
  output logic [icache_geom_pkg::set_w-1:0]     set_o,
  output logic [icache_geom_pkg::tag_w-1:0]     tag_o,
  output logic                                  refill_o
);
  import icache_geom_pkg::*;
  import icache_addr_pkg::*;

  logic [1:0]       state_d, state_q;
  // cache enable, only set at the end of a flush
  logic             cache_en_d, cache_en_q;
  // flush request waiting for idle
  logic             flush_d, flush_q;
  logic [set_w-1:0] flush_cnt_d, flush_cnt_q;
  logic             flush_done;
  // latched request address
  fetch_addr_u      req_q;
  logic             req_we;

  assign flush_done = (flush_cnt_q == set_w'(num_sets - 1));

  // memory request lives for the whole refill state
  assign mem_cyc_o  = (state_q == st_refill);
  assign mem_stb_o  = (state_q == st_refill);
  assign mem_adr_o  = line_base(req_q);
  assign tag_o      = get_tag(req_q);
  assign busy_o     = (state_q != st_idle);

  ////////////////////////////////////////
  // next state logic
  ////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    // dropping the enable takes effect at once
    cache_en_d  = cache_en_q & en_i;
    flush_d     = flush_q | flush_i;
    flush_cnt_d = flush_cnt_q;
    req_we      = 1'b0;
    rd_en_o     = 1'b0;
    fill_we_o   = 1'b0;
    clear_we_o  = 1'b0;
    fetch_ack_o = 1'b0;
    miss_o      = 1'b0;
    refill_o    = 1'b0;
    // arrays follow the latched request unless told otherwise
    set_o       = get_set(req_q);

    unique case (state_q)
      // walk all sets and clear their valid bits
      st_flush: begin
        clear_we_o  = 1'b1;
        set_o       = flush_cnt_q;
        // wraps back to zero after the last set
        flush_cnt_d = flush_cnt_q + 1'b1;
        if (flush_done) begin
          state_d    = st_idle;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      // pending flush or a fresh enable go first
      st_idle: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = st_flush;
        end else if (fetch_cyc_i && fetch_stb_i) begin
          // read all ways of the requested set on this edge
          req_we  = 1'b1;
          rd_en_o = cache_en_q;
          set_o   = get_set(fetch_adr_i);
          state_d = st_lookup;
        end
      end
      // arrays are valid now
      st_lookup: begin
        if (hit_i && cache_en_q) begin
          fetch_ack_o = 1'b1;
          state_d     = st_idle;
        end else begin
          // a disabled cache does not count misses
          miss_o  = cache_en_q;
          state_d = st_refill;
        end
      end
      // wait for the line, pass the word through on the ack
      st_refill: begin
        refill_o = 1'b1;
        if (mem_ack_i) begin
          fetch_ack_o = 1'b1;
          fill_we_o   = cache_en_q;
          state_d     = st_idle;
        end
      end
    endcase
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= st_idle;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  // request address, held until the next accepted fetch
  always_ff @(posedge clk_i) begin
    if (req_we) begin
      req_q <= fetch_adr_i;
    end
  end

endmodule

//--- hdl/icache_geom_pkg.sv
// instruction cache geometry
package icache_geom_pkg;

  ////////////////////////////////////////
  // bus and line widths
  ////////////////////////////////////////

  // fetch and memory byte address
  localparam int unsigned addr_w   = 32;
  // one instruction word toward the cpu
  localparam int unsigned word_w   = 32;
  // one full line, also the memory data bus
  localparam int unsigned line_w   = 128;

  ////////////////////////////////////////
  // organisation
  ////////////////////////////////////////

  localparam int unsigned num_ways = 4;
  localparam int unsigned way_w    = $clog2(num_ways);
  localparam int unsigned num_sets = 64;
  localparam int unsigned set_w    = $clog2(num_sets);
  // byte offset inside a line
  localparam int unsigned offset_w = $clog2(line_w / 8);
  localparam int unsigned tag_w    = addr_w - set_w - offset_w;

  // replacement lfsr start value, must not be zero
  localparam logic [7:0] lfsr_seed = 8'hb5;

  // controller state codes
  localparam logic [1:0] st_flush  = 2'd0;
  localparam logic [1:0] st_idle   = 2'd1;
  localparam logic [1:0] st_lookup = 2'd2;
  localparam logic [1:0] st_refill = 2'd3;

endpackage

//--- hdl/icache_hit_select.sv
// hit detection and word select
module icache_hit_select (
  input  logic [icache_geom_pkg::num_ways-1:0][icache_geom_pkg::tag_w-1:0]  tag_i,
  input  logic [icache_geom_pkg::num_ways-1:0]                              valid_i,
  input  logic [icache_geom_pkg::num_ways-1:0][icache_geom_pkg::line_w-1:0] line_i,
  input  logic [icache_geom_pkg::tag_w-1:0]                                 req_tag_i,
  // request address, only the word field is used
  input  icache_addr_pkg::fetch_addr_u                                      word_sel_i,
  input  logic                                                              refill_i,
  input  logic [icache_geom_pkg::line_w-1:0]                                mem_line_i,
  output logic                                                              hit_o,
  output logic [icache_geom_pkg::word_w-1:0]                                word_o
);
  import icache_geom_pkg::*;
  import icache_addr_pkg::*;

  logic [num_ways-1:0] hit_vec;
  logic [way_w-1:0]    hit_way;
  logic [offset_w-3:0] word_idx;
  logic [word_w-1:0]   hit_word;
  logic [word_w-1:0]   mem_word;

  assign word_idx = get_word(word_sel_i);

  // tag compare, qualified by valid
  for (genvar w = 0; w < num_ways; w++) begin : gen_cmp
    assign hit_vec[w] = valid_i[w] && (tag_i[w] == req_tag_i);
  end

  // lowest hitting way wins
  always_comb begin
    hit_way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = way_w'(w);
      end
    end
  end

  assign hit_o    = |hit_vec;
  assign hit_word = line_i[hit_way][word_idx * word_w +: word_w];
  assign mem_word = mem_line_i[word_idx * word_w +: word_w];

  // during refill the word comes straight from memory
  assign word_o   = refill_i ? mem_word : hit_word;

endmodule

//--- hdl/icache_replace.sv
// refill way selection
module icache_replace (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic [icache_geom_pkg::num_ways-1:0]   valid_i,
  input  logic                                   fill_we_i,
  output logic [icache_geom_pkg::way_w-1:0]      way_o
);
  import icache_geom_pkg::*;

  logic [7:0]       lfsr_d, lfsr_q;
  logic [way_w-1:0] inv_way;
  logic             all_valid;

  assign all_valid = &valid_i;

  // first invalid way, searched from the top so way 0 wins
  always_comb begin
    inv_way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = way_w'(w);
      end
    end
  end

  ////////////////////////////////////////
  // random pick once the set is full
  ////////////////////////////////////////

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign lfsr_d = {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};

  // steps only when a full set gets a line replaced
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= lfsr_seed;
    end else if (fill_we_i && all_valid) begin
      lfsr_q <= lfsr_d;
    end
  end

  assign way_o = all_valid ? lfsr_q[way_w-1:0] : inv_way;

endmodule

//--- hdl/icache_top.sv
// instruction cache top level
module icache_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // cpu fetch port
  input  logic                                 fetch_cyc_i,
  input  logic                                 fetch_stb_i,
  input  icache_addr_pkg::fetch_addr_u         fetch_adr_i,
  output logic [icache_geom_pkg::word_w-1:0]   fetch_dat_o,
  output logic                                 fetch_ack_o,
  // memory line port
  output logic                                 mem_cyc_o,
  output logic                                 mem_stb_o,
  output logic [icache_geom_pkg::addr_w-1:0]   mem_adr_o,
  input  logic [icache_geom_pkg::line_w-1:0]   mem_dat_i,
  input  logic                                 mem_ack_i,
  // control and status
  input  logic                                 flush_i,
  input  logic                                 en_i,
  output logic                                 miss_o,
  output logic                                 busy_o
);
  import icache_geom_pkg::*;

  logic                               rd_en;
  logic                               fill_we;
  logic                               clear_we;
  logic [set_w-1:0]                   set_idx;
  logic [tag_w-1:0]                   req_tag;
  logic                               refill;
  logic                               hit;
  logic [way_w-1:0]                   refill_way;
  logic [num_ways-1:0][tag_w-1:0]     way_tag;
  logic [num_ways-1:0]                way_valid;
  logic [num_ways-1:0][line_w-1:0]    way_line;

  icache_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_cyc_i (fetch_cyc_i),
    .fetch_stb_i (fetch_stb_i),
    .fetch_adr_i (fetch_adr_i),
    .fetch_ack_o (fetch_ack_o),
    .flush_i     (flush_i),
    .en_i        (en_i),
    .miss_o      (miss_o),
    .busy_o      (busy_o),
    .hit_i       (hit),
    .mem_cyc_o   (mem_cyc_o),
    .mem_stb_o   (mem_stb_o),
    .mem_adr_o   (mem_adr_o),
    .mem_ack_i   (mem_ack_i),
    .rd_en_o     (rd_en),
    .fill_we_o   (fill_we),
    .clear_we_o  (clear_we),
    .set_o       (set_idx),
    .tag_o       (req_tag),
    .refill_o    (refill)
  );

  // fills take the line straight from the memory bus
  icache_arrays i_arrays (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_en_i    (rd_en),
    .fill_we_i  (fill_we),
    .clear_we_i (clear_we),
    .set_i      (set_idx),
    .tag_i      (req_tag),
    .way_i      (refill_way),
    .line_i     (mem_dat_i),
    .tag_o      (way_tag),
    .valid_o    (way_valid),
    .line_o     (way_line)
  );

  // word offset comes from the held cpu address
  icache_hit_select i_hit (
    .tag_i      (way_tag),
    .valid_i    (way_valid),
    .line_i     (way_line),
    .req_tag_i  (req_tag),
    .word_sel_i (fetch_adr_i),
    .refill_i   (refill),
    .mem_line_i (mem_dat_i),
    .hit_o      (hit),
    .word_o     (fetch_dat_o)
  );

  icache_replace i_replace (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (way_valid),
    .fill_we_i (fill_we),
    .way_o     (refill_way)
  );

endmodule

//--- test/icache_assertions.sv
// wishbone protocol assertions
module icache_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic fetch_cyc_i,
  input logic fetch_stb_i,
  input logic fetch_ack_o,
  input logic mem_cyc_o,
  input logic mem_stb_o,
  input logic mem_ack_i
);

  // cpu side strobe only inside a cycle
  a_fetch_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_stb_i |-> fetch_cyc_i)
    else $error("fetch stb high without cyc");

  // memory cycle and strobe close in the cycle after the ack
  a_mem_cyc_close: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_cyc_o && mem_ack_i) |=> (!mem_cyc_o && !mem_stb_o))
    else $error("mem cycle still open after ack");

  // no ack toward the cpu unless a request is open
  a_fetch_ack_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_ack_o |-> fetch_stb_i)
    else $error("fetch ack without stb");

  // line request is held until memory answers
  a_mem_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_stb_o && !mem_ack_i) |=> mem_stb_o)
    else $error("mem stb dropped before ack");

endmodule

bind icache_ctrl icache_assertions i_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .fetch_cyc_i (fetch_cyc_i),
  .fetch_stb_i (fetch_stb_i),
  .fetch_ack_o (fetch_ack_o),
  .mem_cyc_o   (mem_cyc_o),
  .mem_stb_o   (mem_stb_o),
  .mem_ack_i   (mem_ack_i)
);

//--- test/icache_tb.sv
// instruction cache testbench
module icache_tb;
  import icache_geom_pkg::*;
  import icache_addr_pkg::*;

  localparam int num_tests = 5;

  logic              clk;
  logic              rst_n;
  logic              fetch_cyc;
  logic              fetch_stb;
  fetch_addr_u       fetch_adr;
  logic [word_w-1:0] fetch_dat;
  logic              fetch_ack;
  logic              mem_cyc;
  logic              mem_stb;
  logic [addr_w-1:0] mem_adr;
  logic [line_w-1:0] mem_dat;
  logic              mem_ack;
  logic              flush;
  logic              en;
  logic              miss;
  logic              busy;

  integer            seed;
  int                mem_count;
  int                miss_count;
  logic [addr_w-1:0] line_adr;
  // address cached by the first test, reused later
  logic [addr_w-1:0] first_adr;
  // five tags sharing one set
  logic [addr_w-1:0] set_adr [5];

  icache_top i_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .fetch_cyc_i (fetch_cyc),
    .fetch_stb_i (fetch_stb),
    .fetch_adr_i (fetch_adr),
    .fetch_dat_o (fetch_dat),
    .fetch_ack_o (fetch_ack),
    .mem_cyc_o   (mem_cyc),
    .mem_stb_o   (mem_stb),
    .mem_adr_o   (mem_adr),
    .mem_dat_i   (mem_dat),
    .mem_ack_i   (mem_ack),
    .flush_i     (flush),
    .en_i        (en),
    .miss_o      (miss),
    .busy_o      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  // word i of line A reads back as (A + 4i) ^ c0de0000
  function automatic logic [word_w-1:0] model_word(input logic [addr_w-1:0] addr);
    logic [addr_w-1:0] base;
    base = {addr[addr_w-1:offset_w], {offset_w{1'b0}}};
    return (base + addr_w'(4 * addr[offset_w-1:2])) ^ 32'hc0de_0000;
  endfunction

  // answers each line request two cycles after it shows up
  initial begin
    mem_ack   = 1'b0;
    mem_dat   = '0;
    mem_count = 0;
    forever begin
      @(negedge clk);
      if (mem_cyc && mem_stb) begin
        mem_count++;
        line_adr = mem_adr;
        repeat (2) @(posedge clk);
        #1;
        for (int i = 0; i < line_w / word_w; i++) begin
          mem_dat[i * word_w +: word_w] = (line_adr + addr_w'(4 * i)) ^ 32'hc0de_0000;
        end
        mem_ack = 1'b1;
        @(posedge clk);
        #1;
        mem_ack = 1'b0;
      end
    end
  end

  // miss pulses for the perf counter
  initial miss_count = 0;
  always @(negedge clk) begin
    if (rst_n && miss) begin
      miss_count++;
    end
  end

  ////////////////////////////////////////
  // checks and bus helpers
  ////////////////////////////////////////

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input logic [addr_w-1:0] addr, input logic [word_w-1:0] got,
                            input logic [word_w-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("ERR @%0t: fetch of %h returned %h, expected %h",
                               $time, addr, got, exp));
    end
  endtask

  task automatic check_count(input string what, input int got, input int lo, input int hi);
    if (got < lo || got > hi) begin
      report_failure($sformatf("ERR @%0t: %s is %0d, expected %0d to %0d",
                               $time, what, got, lo, hi));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // one classic read; lat counts cycles of stb before ack
  task automatic fetch_word(input logic [addr_w-1:0] addr, output logic [word_w-1:0] data,
                            output int lat);
    int n;
    n = 0;
    fetch_cyc     = 1'b1;
    fetch_stb     = 1'b1;
    fetch_adr.raw = addr;
    @(negedge clk);
    while (!fetch_ack) begin
      n++;
      if (n > 100) begin
        report_failure($sformatf("no ack for the fetch of %h", addr));
      end
      @(negedge clk);
    end
    data = fetch_dat;
    lat  = n;
    next_cycle();
    fetch_cyc = 1'b0;
    fetch_stb = 1'b0;
  endtask

  task automatic fetch_and_count(input logic [addr_w-1:0] addr, input int mem_new,
                                 input int miss_new, output int lat);
    int                m0;
    int                s0;
    logic [word_w-1:0] data;
    m0 = mem_count;
    s0 = miss_count;
    fetch_word(addr, data, lat);
    check_word(addr, data, model_word(addr));
    check_count("memory transactions", mem_count - m0, mem_new, mem_new);
    check_count("miss pulses", miss_count - s0, miss_new, miss_new);
  endtask

  // busy must rise, then stay high for one pass over the sets
  task automatic wait_for_flush();
    int n;
    n = 0;
    @(negedge clk);
    while (!busy) begin
      n++;
      if (n > 10) begin
        report_failure("busy_o never rose after the flush request");
      end
      @(negedge clk);
    end
    n = 0;
    while (busy) begin
      n++;
      if (n > 4 * num_sets) begin
        report_failure("busy_o stuck high during the flush");
      end
      @(negedge clk);
    end
    check_count("flush cycles", n, num_sets, num_sets);
    next_cycle();
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic cold_miss_then_hit();
    int lat;
    en = 1'b1;
    wait_for_flush();
    first_adr = $random(seed);
    fetch_and_count(first_adr, 1, 1, lat);
    fetch_and_count(first_adr, 0, 0, lat);
    check_count("hit latency", lat, 1, 1);
  endtask

  task automatic fill_four_ways();
    fetch_addr_u a;
    int          lat;
    for (int k = 0; k < 5; k++) begin
      a.raw        = $random(seed);
      // neighbour set of the first test, low tag bits keep tags apart
      a.f.set_idx  = first_adr[offset_w +: set_w] + 1'b1;
      a.f.tag[2:0] = 3'(k);
      set_adr[k]   = a.raw;
    end
    for (int k = 0; k < 4; k++) begin
      fetch_and_count(set_adr[k], 1, 1, lat);
    end
    for (int k = 0; k < 4; k++) begin
      fetch_and_count(set_adr[k], 0, 0, lat);
      check_count("hit latency", lat, 1, 1);
    end
  endtask

  task automatic evict_fifth_tag();
    logic [word_w-1:0] data;
    int                lat;
    int                m0;
    fetch_and_count(set_adr[4], 1, 1, lat);
    // five lines in four ways, every pass misses at least once
    for (int pass = 0; pass < 2; pass++) begin
      m0 = mem_count;
      for (int k = 0; k < 5; k++) begin
        fetch_word(set_adr[k], data, lat);
        check_word(set_adr[k], data, model_word(set_adr[k]));
      end
      check_count("transactions per pass", mem_count - m0, 1, 5);
    end
  endtask

  task automatic flush_clears_lines();
    int lat;
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    wait_for_flush();
    fetch_and_count(first_adr, 1, 1, lat);
  endtask

  task automatic disabled_bypass();
    int lat;
    en = 1'b0;
    next_cycle();
    next_cycle();
    // still cached, but a disabled cache goes to memory every time
    for (int k = 0; k < 3; k++) begin
      fetch_and_count(first_adr, 1, 0, lat);
    end
  endtask

  ////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////

  initial begin
    #(num_tests * 2000);
    report_failure("watchdog expired before the tests finished");
  end

  initial begin
    seed          = 32'h7eea;
    rst_n         = 1'b0;
    fetch_cyc     = 1'b0;
    fetch_stb     = 1'b0;
    fetch_adr.raw = '0;
    flush         = 1'b0;
    en            = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    cold_miss_then_hit();
    fill_four_ways();
    evict_fifth_tag();
    flush_clears_lines();
    disabled_bypass();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
